// File: all.f
+incdir+source
source/exec_op_pkg.sv
source/exec_data_pkg.sv
source/exec_alu.sv
source/exec_cfu.sv
source/exec_writeback.sv
source/exec_stage.sv
bench/tb_exec_stage.sv

// File: bench/exec_testdata.txt
// First word: vector count. Then per line: pc opr_a opr_b opr_c rd alu_op cfu_op mtvec
// then expected: wen addr wdata cf_valid target trap cause (all hex)
00000028
00000100 00000005 00000003 00000000 01 1 0 00000080 1 01 00000008 0 00000000 0 00
00000104 ffffffff 00000002 00000000 02 1 0 00000080 1 02 00000001 0 00000000 0 00
00000108 00000010 00000020 00000000 03 2 0 00000080 1 03 fffffff0 0 00000000 0 00
0000010c f0f0f0f0 0ff00ff0 00000000 04 3 0 00000080 1 04 ff00ff00 0 00000000 0 00
00000110 12340000 00005678 00000000 05 4 0 00000080 1 05 12345678 0 00000000 0 00
00000114 ff00ff00 0f0f0f0f 00000000 06 5 0 00000080 1 06 0f000f00 0 00000000 0 00
00000118 fffffffe 00000001 00000000 07 6 0 00000080 1 07 00000001 0 00000000 0 00
0000011c 00000001 fffffffe 00000000 08 6 0 00000080 1 08 00000000 0 00000000 0 00
00000120 00000001 fffffffe 00000000 09 7 0 00000080 1 09 00000001 0 00000000 0 00
00000124 fffffffe 00000001 00000000 0a 7 0 00000080 1 0a 00000000 0 00000000 0 00
00000128 80000000 00000004 00000000 0b 8 0 00000080 1 0b 08000000 0 00000000 0 00
0000012c 00000003 00000024 00000000 0c 9 0 00000080 1 0c 00000030 0 00000000 0 00
00000130 80000000 00000004 00000000 0d a 0 00000080 1 0d f8000000 0 00000000 0 00
00000134 7ffffff0 0000001f 00000000 0e a 0 00000080 1 0e 00000000 0 00000000 0 00
00000138 00000055 000000aa 00000000 0f 0 0 00000080 0 00 00000000 0 00000000 0 00
0000013c 00000001 00000001 00000000 00 1 0 00000080 1 00 00000002 0 00000000 0 00
00001000 00000005 00000005 00000010 00 0 4 00000080 0 00 00000000 1 00001010 0 00
00001000 00000005 00000006 00000010 00 0 4 00000080 0 00 00000000 0 00000000 0 00
00001000 00000005 00000006 fffffff0 00 0 5 00000080 0 00 00000000 1 00000ff0 0 00
00001000 00000007 00000007 00000010 00 0 5 00000080 0 00 00000000 0 00000000 0 00
00001000 ffffffff 00000001 00000020 00 0 6 00000080 0 00 00000000 1 00001020 0 00
00001000 00000001 ffffffff 00000020 00 0 6 00000080 0 00 00000000 0 00000000 0 00
00001000 00000001 ffffffff 00000008 00 0 7 00000080 0 00 00000000 1 00001008 0 00
00001000 ffffffff 00000001 00000008 00 0 7 00000080 0 00 00000000 0 00000000 0 00
00001000 00000001 ffffffff 00000100 00 0 8 00000080 0 00 00000000 1 00001100 0 00
00001000 ffffffff 00000001 00000100 00 0 8 00000080 0 00 00000000 0 00000000 0 00
00001000 00000003 00000003 00000004 00 0 9 00000080 0 00 00000000 1 00001004 0 00
00001000 00000001 00000002 00000004 00 0 9 00000080 0 00 00000000 0 00000000 0 00
00002000 00002000 00000040 00002004 01 0 2 00000080 1 01 00002004 1 00002040 0 00
00002004 00003001 00000004 00002008 05 0 3 00000080 1 05 00002008 1 00003004 0 00
00002008 00004000 ffffffff 0000200c 1f 0 3 00000080 1 1f 0000200c 1 00003ffe 0 00
0000200c 00002000 00000100 00002010 00 0 1 00000080 0 00 00000000 1 00002100 0 00
00002010 00005000 00000010 00005004 00 0 2 00000080 1 00 00005004 1 00005010 0 00
00006000 00000000 00000000 00000000 00 0 a 00000100 0 00 00000000 1 00000100 1 0b
00001000 00000001 00000001 00000003 00 0 4 00000200 0 00 00000000 1 00000200 1 00
00002000 00002000 00000011 00000000 00 0 1 00000300 0 00 00000000 1 00000300 1 00
00006004 00000001 00000002 00000000 03 1 a 00000400 0 00 00000000 1 00000400 1 0b
00007000 00000002 00000002 00000040 04 1 4 00000080 0 00 00000000 1 00007040 0 00
00000140 00000100 00000200 00000000 02 1 0 00000080 1 02 00000300 0 00000000 0 00
00000144 12345678 12345678 00000000 03 2 0 00000080 1 03 00000000 0 00000000 0 00

// File: bench/tb_exec_stage.sv
// Execute stage testbench
// Replays the vector file through the decode and fetch handshakes and
// checks writeback, redirect, trap and retire behavior of each instr

`timescale 1ns/10ps

`include "exec_defines.svh"

module tb_exec_stage
    import exec_op_pkg::*, exec_data_pkg::*;
();

    localparam int clk_half      = 20;     // 40 ns period
    localparam int words_per_vec = 15;     // Fields per vector line
    localparam int max_vecs      = 64;

    // ------------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------------

    logic        g_clk;
    logic        g_resetn;
    logic        s2_valid;
    logic        s2_full;
    exec_instr_t s2_instr;
    logic        s2_ready;
    logic        s2_cf_valid;
    cf_req_t     s2_cf;
    logic        s2_cf_ack;
    xword_t      csr_mtvec;
    gpr_wb_t     s2_wb;
    logic        instr_ret;
    logic        trap_cpu;
    trap_cause_t trap_cause;

    logic [`EXEC_XLEN-1:0] vec_mem [0:max_vecs*words_per_vec];  // Word 0 is the count
    int     vec_count;
    int     error_count;
    integer seed;                           // Ack delay generator

    exec_stage u_exec_stage (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .s2_valid    (s2_valid),
        .s2_full     (s2_full),
        .s2_instr    (s2_instr),
        .s2_ready    (s2_ready),
        .s2_cf_valid (s2_cf_valid),
        .s2_cf       (s2_cf),
        .s2_cf_ack   (s2_cf_ack),
        .csr_mtvec   (csr_mtvec),
        .s2_wb       (s2_wb),
        .instr_ret   (instr_ret),
        .trap_cpu    (trap_cpu),
        .trap_cause  (trap_cause)
    );

    always #(clk_half) g_clk = ~g_clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test_name, field, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Present one vector, hold it until the stage is ready, count pulses
    task automatic run_vector(input int v);
        int          base;
        int          ack_delay;
        int          cycle;
        int          ret_count;
        int          wen_count;
        logic        done;
        gpr_wb_t     exp_wb;
        logic        exp_cf_valid;
        cf_req_t     exp_cf;
        trap_cause_t exp_cause;
        string       tag;
        base          = 1 + v * words_per_vec;
        tag           = $sformatf("vec%0d", v);
        exp_wb.wen    = vec_mem[base+8][0];
        exp_wb.addr   = vec_mem[base+9][4:0];
        exp_wb.wdata  = vec_mem[base+10];
        exp_cf_valid  = vec_mem[base+11][0];
        exp_cf.target = vec_mem[base+12];
        exp_cf.trap   = vec_mem[base+13][0];
        exp_cause     = vec_mem[base+14][5:0];
        ack_delay     = int'($unsigned($random(seed)) % 4);    // 0 to 3 cycles

        @(posedge g_clk);
        #1;
        s2_instr.pc     = vec_mem[base];
        s2_instr.opr_a  = vec_mem[base+1];
        s2_instr.opr_b  = vec_mem[base+2];
        s2_instr.opr_c  = vec_mem[base+3];
        s2_instr.rd     = vec_mem[base+4][4:0];
        s2_instr.alu_op = alu_op_e'(vec_mem[base+5][3:0]);
        s2_instr.cfu_op = cfu_op_e'(vec_mem[base+6][3:0]);
        csr_mtvec       = vec_mem[base+7];
        s2_valid        = 1'b1;
        s2_full         = 1'b1;
        s2_cf_ack       = 1'b0;

        cycle     = 0;
        ret_count = 0;
        wen_count = 0;
        done      = 1'b0;
        while (!done) begin
            if (exp_cf_valid && cycle == ack_delay) begin
                s2_cf_ack = 1'b1;           // Fetch takes the change
            end
            @(negedge g_clk);               // Outputs settled mid cycle
            if (instr_ret) begin
                ret_count++;
            end
            if (s2_wb.wen) begin
                wen_count++;
            end
            check_value(tag, "cf_valid", 32'(exp_cf_valid), 32'(s2_cf_valid));
            if (exp_cf_valid) begin
                check_value(tag, "cf_target", exp_cf.target, s2_cf.target);
                check_value(tag, "cf_trap", 32'(exp_cf.trap), 32'(s2_cf.trap));
                check_value(tag, "ready", 32'(cycle == ack_delay), 32'(s2_ready));
            end else begin
                check_value(tag, "ready", 32'h1, 32'(s2_ready));
            end
            check_value(tag, "trap_cpu", 32'(exp_cf.trap), 32'(trap_cpu));
            check_value(tag, "trap_cause", 32'(exp_cause), 32'(trap_cause));
            if (cycle == 0) begin
                check_value(tag, "wb_wen", 32'(exp_wb.wen), 32'(s2_wb.wen));
                if (exp_wb.wen) begin
                    check_value(tag, "wb_addr", 32'(exp_wb.addr), 32'(s2_wb.addr));
                    check_value(tag, "wb_data", exp_wb.wdata, s2_wb.wdata);
                end
            end
            if (s2_ready) begin
                done = 1'b1;                // Accepted at the next edge
            end else begin
                @(posedge g_clk);
                #1;
                cycle++;
            end
        end

        // Trapping instrs retire nothing
        check_value(tag, "ret_count", exp_cf.trap ? 32'h0 : 32'h1, ret_count);
        check_value(tag, "wen_count", 32'(exp_wb.wen), wen_count);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        g_clk       = 1'b0;
        g_resetn    = 1'b0;
        s2_valid    = 1'b0;
        s2_full     = 1'b0;
        s2_instr    = '0;
        s2_cf_ack   = 1'b0;
        csr_mtvec   = '0;
        seed        = 32'h774ede57;
        error_count = 0;

        $readmemh("bench/exec_testdata.txt", vec_mem);
        if (vec_mem[0] == 32'h0 || vec_mem[0] > 32'(max_vecs)) begin
            $display("Vector file is missing, empty or holds too many vectors");
            $display("Finished with errors");
            $fatal(1, "Bad vector file");
        end
        vec_count = int'(vec_mem[0]);

        repeat (2) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        @(negedge g_clk);
        check_value("reset", "cf_valid", 32'h0, 32'(s2_cf_valid));  // Idle after reset
        check_value("reset", "wb_wen", 32'h0, 32'(s2_wb.wen));

        for (int v = 0; v < vec_count; v++) begin
            run_vector(v);
        end

        @(posedge g_clk);
        #1;
        s2_valid  = 1'b0;
        s2_full   = 1'b0;
        s2_cf_ack = 1'b0;
        @(negedge g_clk);
        check_value("drain", "cf_valid", 32'h0, 32'(s2_cf_valid));
        check_value("drain", "wb_wen", 32'h0, 32'(s2_wb.wen));

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Budget of 8 cycles per vector against a worst case of 4
    initial begin
        wait (vec_count != 0);
        #((vec_count * 8 + 10) * 2 * clk_half);
        $display("Timeout: the vectors did not complete within the allowed time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator.
# The result is decided by searching the simulation log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary -j 0 --timescale 1ns/10ps --top-module tb_exec_stage \
    -f all.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_exec_stage > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log \
    || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0

// File: source/exec_alu.sv
// Integer ALU
// Single cycle add/sub, logic, compare and shift unit; also exports the
// adder output and comparison flags for branch resolution

`timescale 1ns/10ps

module exec_alu
    import exec_op_pkg::*, exec_data_pkg::*;
(
    input  exec_instr_t instr,      // Decoded instr
    output alu_flags_t  flags,      // Adder output and compare flags
    output xword_t      result      // Selected op result
);

    // ------------------------------------------------------------------------
    // Operands and adder
    // ------------------------------------------------------------------------

    xword_t     opr_a;
    xword_t     opr_b;
    logic [4:0] shamt;
    logic       op_sub;

    assign opr_a  = instr.opr_a;
    assign opr_b  = instr.opr_b;
    assign shamt  = opr_b[4:0];                 // Shift amount, low 5 bits
    assign op_sub = instr.alu_op == alu_sub;

    // Shared adder that also forms jalr targets
    assign flags.add_out = op_sub ? opr_a - opr_b : opr_a + opr_b;

    // ------------------------------------------------------------------------
    // Comparisons for every op so branches can use them
    // ------------------------------------------------------------------------

    assign flags.cmp_eq  = opr_a == opr_b;
    assign flags.cmp_lt  = $signed(opr_a) < $signed(opr_b);
    assign flags.cmp_ltu = opr_a < opr_b;

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------

    always_comb begin
        case (instr.alu_op)
            alu_add,
            alu_sub: begin
                result = flags.add_out;             // Add or subtract
            end
            alu_xor: begin
                result = opr_a ^ opr_b;
            end
            alu_or: begin
                result = opr_a | opr_b;
            end
            alu_and: begin
                result = opr_a & opr_b;
            end
            alu_slt: begin
                result = xword_t'(flags.cmp_lt);    // Zero extended flag
            end
            alu_sltu: begin
                result = xword_t'(flags.cmp_ltu);
            end
            alu_srl: begin
                result = opr_a >> shamt;
            end
            alu_sll: begin
                result = opr_a << shamt;
            end
            alu_sra: begin
                result = xword_t'($signed(opr_a) >>> shamt);   // Sign fill
            end
            default: begin
                result = '0;                        // nop gives zero
            end
        endcase
    end

endmodule

// File: source/exec_cfu.sv
// Control flow unit
// Resolves branches and jumps, raises ECALL and misaligned target traps,
// drives the change request toward fetch and decides stage readiness

`timescale 1ns/10ps

`include "exec_defines.svh"

module exec_cfu
    import exec_op_pkg::*, exec_data_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,
    input  exec_instr_t instr,          // Decoded instr
    input  alu_flags_t  flags,          // From the ALU
    input  logic        s2_valid,       // Decode has an instr
    input  logic        s2_full,        // Instr really present
    input  logic        s2_cf_ack,      // Fetch took the change
    input  xword_t      csr_mtvec,      // Trap vector
    output logic        s2_cf_valid,    // Change request
    output cf_req_t     s2_cf,          // Target and trap flag
    output logic        s2_ready,       // Stage can take next instr
    output logic        instr_accept,   // Handshake with decode
    output logic        instr_ret,      // Retire pulse
    output logic        trap_cpu,       // Trapping instr present
    output trap_cause_t trap_cause,
    output logic        link_wen,       // jal/jalr write rd
    output xword_t      link_data,
    output logic        cfu_active      // Any CFU op present
);

    // ------------------------------------------------------------------------
    // Op decode
    // ------------------------------------------------------------------------

    logic   op_j, op_jal, op_jalr, op_ecall;
    logic   conditional;                    // Any conditional branch
    logic   always_jump;                    // Unconditional change
    logic   cond_taken;
    xword_t branch_target;
    xword_t jump_target;
    logic   excep_target;                   // Misaligned target
    logic   cf_excep;
    logic   cf_needed;                      // Instr needs a change
    logic   cf_change;                      // Fetch handshake this cycle
    logic   cf_done;                        // Change already taken

    assign op_j     = instr.cfu_op == cfu_j;
    assign op_jal   = instr.cfu_op == cfu_jal;
    assign op_jalr  = instr.cfu_op == cfu_jalr;
    assign op_ecall = instr.cfu_op == cfu_ecall;

    assign conditional = instr.cfu_op inside {cfu_beq, cfu_bne, cfu_blt,
                                              cfu_bltu, cfu_bge, cfu_bgeu};
    assign always_jump = op_j || op_jal || op_jalr || op_ecall;

    // Branch resolution from the ALU flags
    always_comb begin
        case (instr.cfu_op)
            cfu_beq:  cond_taken =  flags.cmp_eq;
            cfu_bne:  cond_taken = !flags.cmp_eq;
            cfu_blt:  cond_taken =  flags.cmp_lt;
            cfu_bltu: cond_taken =  flags.cmp_ltu;
            cfu_bge:  cond_taken = !flags.cmp_lt;
            cfu_bgeu: cond_taken = !flags.cmp_ltu;
            default:  cond_taken = 1'b0;
        endcase
    end

    assign branch_target = instr.pc + instr.opr_c;                  // pc relative
    assign jump_target   = {flags.add_out[`EXEC_XLEN-1:1],
                            flags.add_out[0] && !op_jalr};          // jalr clears bit 0

    // ------------------------------------------------------------------------
    // Exceptions
    // ------------------------------------------------------------------------

    assign excep_target = (conditional && branch_target[0]) ||
                          ((op_j || op_jal) && jump_target[0]);
    assign cf_excep     = op_ecall || excep_target;

    assign trap_cpu   = s2_valid && cf_excep;
    assign trap_cause = op_ecall ? trap_cause_t'(`EXEC_TRAP_ECALL) :
                                   trap_cause_t'(`EXEC_TRAP_TARGET);

    // ------------------------------------------------------------------------
    // Fetch request and the once-per-instr guard
    // ------------------------------------------------------------------------

    assign cf_needed   = cf_excep || cond_taken || always_jump;
    assign s2_cf_valid = s2_valid && cf_needed && !cf_done;
    assign cf_change   = s2_cf_valid && s2_cf_ack;

    assign s2_cf.trap   = cf_excep;
    assign s2_cf.target = cf_excep    ? csr_mtvec     :
                          conditional ? branch_target :
                                        jump_target;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else if (instr_accept) begin
            cf_done <= 1'b0;                // Next instr starts clean
        end else if (cf_change) begin
            cf_done <= 1'b1;
        end
    end

    // Ready once any needed change has been acknowledged
    assign s2_ready     = !cf_needed || cf_change || cf_done;
    assign instr_accept = s2_valid && s2_ready;

    // Trapping instrs never retire
    assign instr_ret = ((instr_accept && s2_full) || cf_change) && !cf_excep;

    // Link write for jal and jalr
    assign link_wen   = op_jal || op_jalr;
    assign link_data  = instr.opr_c;        // Return address from decode
    assign cfu_active = instr.cfu_op != cfu_nop;

endmodule

// File: source/exec_data_pkg.sv
// Execute stage data path types
// Word types and the packed structs passed between decode, execute and fetch

`include "exec_defines.svh"

package exec_data_pkg;

    import exec_op_pkg::*;

    // --------------------------------------------------------------------
    // Scalar types
    // --------------------------------------------------------------------

    typedef logic [`EXEC_XLEN-1:0]       xword_t;       // Data word
    typedef logic [`EXEC_REG_ADDR_W-1:0] reg_addr_t;    // GPR address
    typedef logic [5:0]                  trap_cause_t;  // mcause code

    // --------------------------------------------------------------------
    // Bundles
    // --------------------------------------------------------------------

    // Decoded instruction from decode
    typedef struct packed {
        xword_t    pc;          // PC of this instr
        xword_t    opr_a;       // Operand a
        xword_t    opr_b;       // Operand b
        xword_t    opr_c;       // Branch offset or link value
        reg_addr_t rd;          // Destination register
        alu_op_e   alu_op;
        cfu_op_e   cfu_op;
    } exec_instr_t;

    // ALU side outputs used by the CFU
    typedef struct packed {
        xword_t add_out;        // Adder output
        logic   cmp_eq;         // a == b
        logic   cmp_lt;         // a <  b signed
        logic   cmp_ltu;        // a <  b unsigned
    } alu_flags_t;

    // Control flow change toward fetch
    typedef struct packed {
        xword_t target;         // New fetch address
        logic   trap;           // Change caused by an exception
    } cf_req_t;

    // GPR write port
    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        xword_t    wdata;
    } gpr_wb_t;

endpackage

// File: source/exec_defines.svh
// Execute stage shared definitions
// Data width, register address width and trap cause codes

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// ------------------------------------------------------------------------
// Widths
// ------------------------------------------------------------------------

`define EXEC_XLEN           32      // Data path width
`define EXEC_REG_ADDR_W     5       // GPR address width

// ------------------------------------------------------------------------
// Trap cause codes, as written to mcause by the trap logic
// ------------------------------------------------------------------------

// Environment call from machine mode
`define EXEC_TRAP_ECALL     11

// Instruction address misaligned
`define EXEC_TRAP_TARGET    0

`endif

// File: source/exec_op_pkg.sv
// Execute stage operation encodings
// ALU and control flow unit opcodes as produced by decode

`include "exec_defines.svh"

package exec_op_pkg;

    // --------------------------------------------------------------------
    // ALU operations
    // --------------------------------------------------------------------

    typedef enum logic [3:0] {
        alu_nop  = 4'd0,        // No ALU result, no writeback
        alu_add  = 4'd1,        // a + b
        alu_sub  = 4'd2,        // a - b
        alu_xor  = 4'd3,
        alu_or   = 4'd4,
        alu_and  = 4'd5,
        alu_slt  = 4'd6,        // Signed set less than
        alu_sltu = 4'd7,        // Unsigned set less than
        alu_srl  = 4'd8,        // Logical right shift
        alu_sll  = 4'd9,        // Left shift
        alu_sra  = 4'd10        // Arithmetic right shift
    } alu_op_e;

    // --------------------------------------------------------------------
    // Control flow operations
    // --------------------------------------------------------------------

    typedef enum logic [3:0] {
        cfu_nop   = 4'd0,       // Not a control flow instr
        cfu_j     = 4'd1,       // Jump, no link
        cfu_jal   = 4'd2,       // Jump and link
        cfu_jalr  = 4'd3,       // Jump register and link
        cfu_beq   = 4'd4,
        cfu_bne   = 4'd5,
        cfu_blt   = 4'd6,
        cfu_bltu  = 4'd7,
        cfu_bge   = 4'd8,
        cfu_bgeu  = 4'd9,
        cfu_ecall = 4'd10       // Environment call, always traps
    } cfu_op_e;

endpackage

// File: source/exec_stage.sv
// Execute stage top level
// Joins the ALU, the control flow unit and the writeback select between
// the decode handshake, the fetch redirect and the register file

`timescale 1ns/10ps

module exec_stage
    import exec_op_pkg::*, exec_data_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        s2_valid,       // Decode instr valid
    input  logic        s2_full,        // Instr present
    input  exec_instr_t s2_instr,
    output logic        s2_ready,       // Stage takes the instr
    output logic        s2_cf_valid,    // Redirect toward fetch
    output cf_req_t     s2_cf,
    input  logic        s2_cf_ack,
    input  xword_t      csr_mtvec,
    output gpr_wb_t     s2_wb,          // GPR write port
    output logic        instr_ret,
    output logic        trap_cpu,
    output trap_cause_t trap_cause
);

    // ------------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------------

    alu_flags_t alu_flags;
    xword_t     alu_result;
    alu_op_e    wb_alu_op;              // Op seen by writeback
    logic       instr_accept;
    logic       link_wen;
    xword_t     link_data;
    logic       cfu_active;

    assign wb_alu_op = s2_instr.alu_op;

    // ------------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------------

    exec_alu u_alu (
        .instr  (s2_instr),
        .flags  (alu_flags),
        .result (alu_result)
    );

    exec_cfu u_cfu (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .instr        (s2_instr),
        .flags        (alu_flags),
        .s2_valid     (s2_valid),
        .s2_full      (s2_full),
        .s2_cf_ack    (s2_cf_ack),
        .csr_mtvec    (csr_mtvec),
        .s2_cf_valid  (s2_cf_valid),
        .s2_cf        (s2_cf),
        .s2_ready     (s2_ready),
        .instr_accept (instr_accept),
        .instr_ret    (instr_ret),
        .trap_cpu     (trap_cpu),
        .trap_cause   (trap_cause),
        .link_wen     (link_wen),
        .link_data    (link_data),
        .cfu_active   (cfu_active)
    );

    exec_writeback u_writeback (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s2_valid     (s2_valid),
        .instr_accept (instr_accept),
        .rd           (s2_instr.rd),
        .alu_op       (wb_alu_op),
        .alu_result   (alu_result),
        .link_wen     (link_wen),
        .link_data    (link_data),
        .cfu_active   (cfu_active),
        .s2_wb        (s2_wb)
    );

endmodule

// File: source/exec_writeback.sv
// GPR writeback select
// Picks the link value or the ALU result and lets at most one write
// enable through per instruction

`timescale 1ns/10ps

module exec_writeback
    import exec_op_pkg::*, exec_data_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s2_valid,         // Decode has an instr
    input  logic      instr_accept,     // Instr leaves this cycle
    input  reg_addr_t rd,               // Destination register
    input  alu_op_e   alu_op,
    input  xword_t    alu_result,
    input  logic      link_wen,         // jal/jalr link write
    input  xword_t    link_data,
    input  logic      cfu_active,       // CFU owns this instr
    output gpr_wb_t   s2_wb             // To the register file
);

    // ------------------------------------------------------------------------
    // Write sources
    // ------------------------------------------------------------------------

    logic alu_wen;
    logic rd_done;                      // Write already done

    assign alu_wen = (alu_op != alu_nop) && !cfu_active;

    assign s2_wb.wen   = s2_valid && !rd_done && (link_wen || alu_wen);
    assign s2_wb.addr  = rd;            // x0 left to the regfile
    assign s2_wb.wdata = link_wen ? link_data : alu_result;     // Link first

    // ------------------------------------------------------------------------
    // Once per instr guard
    // ------------------------------------------------------------------------

    // Held while a jump waits on fetch so rd is written only once
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rd_done <= 1'b0;
        end else if (instr_accept) begin
            rd_done <= 1'b0;
        end else if (s2_wb.wen) begin
            rd_done <= 1'b1;
        end
    end

endmodule
